//--- rtl/execute_pkg.sv
// Execute stage package with micro-operation layout, unit and operation codes, data widths
`default_nettype none

package execute_pkg;

    // Data and address widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(XLEN);  // Shift amount taken from operand B

    // Micro-operation layout, low index and width per field
    localparam int MICRO_OP_W  = 13;
    localparam int UNIT_LSB    = 0;
    localparam int UNIT_W      = 2;
    localparam int ALU_OP_LSB  = 2;
    localparam int ALU_OP_W    = 4;
    localparam int BR_COND_LSB = 6;
    localparam int BR_COND_W   = 3;
    localparam int KIND_LSB    = 9;
    localparam int KIND_W      = 2;
    localparam int WB_SEL_LSB  = 11;           // Result or incremented PC
    localparam int WB_EN_LSB   = 12;           // Register write request

    // Result-producing units
    localparam logic [UNIT_W-1:0] UNIT_ALU = 2'd0;
    localparam logic [UNIT_W-1:0] UNIT_MUL = 2'd1;

    // ALU operations
    localparam logic [ALU_OP_W-1:0] ALU_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_SRL  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_SRA  = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_AND  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_OR   = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_XOR  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT  = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd9;

    // Branch conditions
    localparam logic [BR_COND_W-1:0] BR_NONE = 3'd0;
    localparam logic [BR_COND_W-1:0] BR_EQ   = 3'd1;
    localparam logic [BR_COND_W-1:0] BR_NE   = 3'd2;
    localparam logic [BR_COND_W-1:0] BR_LT   = 3'd3;
    localparam logic [BR_COND_W-1:0] BR_GE   = 3'd4;
    localparam logic [BR_COND_W-1:0] BR_LTU  = 3'd5;
    localparam logic [BR_COND_W-1:0] BR_GEU  = 3'd6;

    // Instruction kinds
    localparam logic [KIND_W-1:0] KIND_OTHER  = 2'd0;
    localparam logic [KIND_W-1:0] KIND_BRANCH = 2'd1;
    localparam logic [KIND_W-1:0] KIND_JUMP   = 2'd2;  // Always taken

    // Write-back data selection
    localparam logic WB_RESULT  = 1'b0;
    localparam logic WB_PC_NEXT = 1'b1;

    // Iterative multiplier
    localparam int MUL_CYCLES = 32;
    localparam int MUL_CNT_W  = $clog2(MUL_CYCLES);

endpackage

`default_nettype wire

//--- rtl/operand_stage.sv
// Operand stage that captures an issued operation and precomputes its comparison flags
`default_nettype none
`timescale 1ns/1ps

module operand_stage (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                issue_valid_i,
    input  logic                                accept_i,      // Stage ready level
    input  logic [execute_pkg::MICRO_OP_W-1:0]  micro_op_i,
    input  logic [execute_pkg::REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [execute_pkg::XLEN-1:0]        pc_next_i,
    input  logic [execute_pkg::XLEN-1:0]        operand_a_i,
    input  logic [execute_pkg::XLEN-1:0]        operand_b_i,
    output logic                                op_valid_o,
    output logic [execute_pkg::MICRO_OP_W-1:0]  micro_op_o,
    output logic [execute_pkg::REG_ADDR_W-1:0]  rd_addr_o,
    output logic [execute_pkg::XLEN-1:0]        pc_next_o,
    output logic [execute_pkg::XLEN-1:0]        operand_a_o,
    output logic [execute_pkg::XLEN-1:0]        operand_b_o,
    output logic                                lt_o,          // Signed A < B
    output logic                                ltu_o,         // Unsigned A < B
    output logic                                eq_o
);

    logic capture;
    logic lt_in;
    logic ltu_in;
    logic eq_in;

    // Issue while not ready is dropped
    assign capture = issue_valid_i & accept_i;

    // Compare before the register so the flags arrive with the operation
    assign lt_in  = $signed(operand_a_i) < $signed(operand_b_i);
    assign ltu_in = operand_a_i < operand_b_i;
    assign eq_in  = operand_a_i == operand_b_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            op_valid_o <= 1'b0;
        end else begin
            op_valid_o <= capture;  // One cycle per accepted issue
        end
    end

    // Operation payload, only meaningful while op_valid_o is high
    always_ff @(posedge clk_i) begin
        if (capture) begin
            micro_op_o  <= micro_op_i;
            rd_addr_o   <= rd_addr_i;
            pc_next_o   <= pc_next_i;
            operand_a_o <= operand_a_i;
            operand_b_o <= operand_b_i;
            lt_o        <= lt_in;
            ltu_o       <= ltu_in;
            eq_o        <= eq_in;
        end
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
// Arithmetic-logic unit for add, subtract, shifts, logic operations and set-less-than
`default_nettype none
`timescale 1ns/1ps

module alu (
    input  logic [execute_pkg::ALU_OP_W-1:0] alu_op_i,
    input  logic [execute_pkg::XLEN-1:0]     operand_a_i,
    input  logic [execute_pkg::XLEN-1:0]     operand_b_i,
    input  logic                             lt_i,         // Precomputed signed compare
    input  logic                             ltu_i,        // Precomputed unsigned compare
    output logic [execute_pkg::XLEN-1:0]     result_o
);

    import execute_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = operand_b_i[SHAMT_W-1:0];  // Only the low five bits shift

    always_comb begin
        case (alu_op_i)
            ALU_ADD: begin
                result_o = operand_a_i + operand_b_i;  // Also the branch and jump target
            end
            ALU_SUB: begin
                result_o = operand_a_i - operand_b_i;
            end
            ALU_SLL: begin
                result_o = operand_a_i << shamt;
            end
            ALU_SRL: begin
                result_o = operand_a_i >> shamt;
            end
            ALU_SRA: begin
                result_o = $signed(operand_a_i) >>> shamt;  // Sign bit fills from the top
            end
            ALU_AND: begin
                result_o = operand_a_i & operand_b_i;
            end
            ALU_OR: begin
                result_o = operand_a_i | operand_b_i;
            end
            ALU_XOR: begin
                result_o = operand_a_i ^ operand_b_i;
            end
            ALU_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_i};
            end
            ALU_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, ltu_i};
            end
            default: begin
                result_o = '0;  // Unused codes give zero
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/multiplier.sv
// Iterative shift-add multiplier that keeps the low word of the product
`default_nettype none
`timescale 1ns/1ps

module multiplier (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         start_i,
    input  logic [execute_pkg::XLEN-1:0] multiplicand_i,
    input  logic [execute_pkg::XLEN-1:0] multiplier_i,
    output logic                         busy_o,
    output logic                         done_o,         // One cycle, product valid
    output logic [execute_pkg::XLEN-1:0] product_o
);

    import execute_pkg::*;

    logic [XLEN-1:0]      mcand_q;   // Multiplicand, shifted left each step
    logic [XLEN-1:0]      mplier_q;  // Multiplier, shifted right each step
    logic [MUL_CNT_W-1:0] cnt_q;     // Steps still to do after the current one
    logic [XLEN-1:0]      acc_src;
    logic [XLEN-1:0]      mcand_src;
    logic [XLEN-1:0]      mplier_src;
    logic                 step;
    logic                 last_step;

    // The start cycle already performs the first step
    assign step       = start_i | busy_o;
    assign acc_src    = start_i ? '0 : product_o;
    assign mcand_src  = start_i ? multiplicand_i : mcand_q;
    assign mplier_src = start_i ? multiplier_i : mplier_q;
    assign last_step  = busy_o && (cnt_q == MUL_CNT_W'(1));

    // Control state
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_o <= last_step;
            if (start_i) begin
                busy_o <= 1'b1;
                cnt_q  <= MUL_CNT_W'(MUL_CYCLES - 1);
            end else if (busy_o) begin
                busy_o <= !last_step;
                cnt_q  <= cnt_q - 1'b1;
            end
        end
    end

    // Datapath, one partial product added per step
    always_ff @(posedge clk_i) begin
        if (step) begin
            product_o <= acc_src + (mplier_src[0] ? mcand_src : '0);
            mcand_q   <= mcand_src << 1;
            mplier_q  <= mplier_src >> 1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute_unit.sv
// Execute unit that routes operands to the ALU and multiplier, resolves branches and paces issue
`default_nettype none
`timescale 1ns/1ps

module execute_unit (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                op_valid_i,
    input  logic [execute_pkg::MICRO_OP_W-1:0]  micro_op_i,
    input  logic [execute_pkg::REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [execute_pkg::XLEN-1:0]        pc_next_i,
    input  logic [execute_pkg::XLEN-1:0]        operand_a_i,
    input  logic [execute_pkg::XLEN-1:0]        operand_b_i,
    input  logic                                lt_i,
    input  logic                                ltu_i,
    input  logic                                eq_i,
    output logic                                result_valid_o,
    output logic [execute_pkg::XLEN-1:0]        result_o,
    output logic [execute_pkg::MICRO_OP_W-1:0]  micro_op_o,
    output logic [execute_pkg::REG_ADDR_W-1:0]  rd_addr_o,
    output logic [execute_pkg::XLEN-1:0]        pc_next_o,
    output logic [execute_pkg::XLEN-1:0]        branch_target_o,
    output logic                                branch_taken_o,
    output logic [execute_pkg::XLEN-1:0]        fwd_value_o,
    output logic                                ready_o
);

    import execute_pkg::*;

    logic [UNIT_W-1:0]     unit;
    logic [BR_COND_W-1:0]  br_cond;
    logic [KIND_W-1:0]     kind;
    logic                  alu_valid;
    logic                  mul_start;
    logic                  mul_busy;
    logic                  mul_done;
    logic                  cond_met;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       mul_product;
    logic [MICRO_OP_W-1:0] mul_micro_op_q;  // Record parked during a multiply
    logic [REG_ADDR_W-1:0] mul_rd_addr_q;
    logic [XLEN-1:0]       mul_pc_next_q;

    assign unit    = micro_op_i[UNIT_LSB +: UNIT_W];
    assign br_cond = micro_op_i[BR_COND_LSB +: BR_COND_W];
    assign kind    = micro_op_i[KIND_LSB +: KIND_W];

    assign alu_valid = op_valid_i && (unit == UNIT_ALU);
    assign mul_start = op_valid_i && (unit == UNIT_MUL);

    alu u_alu (
        .alu_op_i    (micro_op_i[ALU_OP_LSB +: ALU_OP_W]),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .lt_i        (lt_i),
        .ltu_i       (ltu_i),
        .result_o    (alu_result)
    );

    multiplier u_multiplier (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (mul_start),
        .multiplicand_i (operand_a_i),
        .multiplier_i   (operand_b_i),
        .busy_o         (mul_busy),
        .done_o         (mul_done),
        .product_o      (mul_product)
    );

    always_ff @(posedge clk_i) begin
        if (mul_start) begin
            mul_micro_op_q <= micro_op_i;
            mul_rd_addr_q  <= rd_addr_i;
            mul_pc_next_q  <= pc_next_i;
        end
    end

    // Multiply completion takes the output slot, no ALU op can be in flight then
    assign result_valid_o = alu_valid | mul_done;
    assign result_o       = mul_done ? mul_product : alu_result;
    assign micro_op_o     = mul_done ? mul_micro_op_q : micro_op_i;
    assign rd_addr_o      = mul_done ? mul_rd_addr_q : rd_addr_i;
    assign pc_next_o      = mul_done ? mul_pc_next_q : pc_next_i;
    assign fwd_value_o    = result_o;  // Value heading to write-back

    always_comb begin
        case (br_cond)
            BR_EQ:   cond_met = eq_i;
            BR_NE:   cond_met = !eq_i;
            BR_LT:   cond_met = lt_i;
            BR_GE:   cond_met = !lt_i;
            BR_LTU:  cond_met = ltu_i;
            BR_GEU:  cond_met = !ltu_i;
            default: cond_met = 1'b0;  // BR_NONE and spare codes never branch
        endcase
    end

    // Decode sets ALU_ADD on branches and jumps, so the ALU output is A+B
    assign branch_target_o = alu_result;
    assign branch_taken_o  = op_valid_i &&
                             ((kind == KIND_JUMP) || ((kind == KIND_BRANCH) && cond_met));

    // Low from the start cycle until the multiplier finishes
    assign ready_o = !mul_busy && !mul_start;

endmodule

`default_nettype wire

//--- rtl/writeback_stage.sv
// Write-back stage that picks the write data, qualifies the enable and registers the record
`default_nettype none
`timescale 1ns/1ps

module writeback_stage (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                result_valid_i,
    input  logic [execute_pkg::XLEN-1:0]        result_i,
    input  logic [execute_pkg::MICRO_OP_W-1:0]  micro_op_i,
    input  logic [execute_pkg::REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [execute_pkg::XLEN-1:0]        pc_next_i,
    output logic                                wb_we_o,
    output logic [execute_pkg::REG_ADDR_W-1:0]  wb_rd_addr_o,
    output logic [execute_pkg::XLEN-1:0]        wb_data_o
);

    import execute_pkg::*;

    logic            we_next;
    logic [XLEN-1:0] data_next;

    // Jumps write the return address instead of the unit result
    assign data_next = (micro_op_i[WB_SEL_LSB] == WB_PC_NEXT) ? pc_next_i : result_i;

    // Register zero is hardwired, writes to it are dropped
    assign we_next = result_valid_i && micro_op_i[WB_EN_LSB] && (rd_addr_i != '0);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_we_o      <= 1'b0;
            wb_rd_addr_o <= '0;
            wb_data_o    <= '0;
        end else begin
            wb_we_o      <= we_next;  // High for one cycle per record
            wb_rd_addr_o <= rd_addr_i;
            wb_data_o    <= data_next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/execute_top.sv
// Execute stage top level joining the operand, execute and write-back stages
`default_nettype none
`timescale 1ns/1ps

module execute_top (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  logic                                issue_valid_i,
    input  logic [execute_pkg::MICRO_OP_W-1:0]  micro_op_i,
    input  logic [execute_pkg::REG_ADDR_W-1:0]  rd_addr_i,
    input  logic [execute_pkg::XLEN-1:0]        pc_next_i,
    input  logic [execute_pkg::XLEN-1:0]        operand_a_i,
    input  logic [execute_pkg::XLEN-1:0]        operand_b_i,
    output logic                                ready_o,
    output logic [execute_pkg::XLEN-1:0]        branch_target_o,
    output logic                                branch_taken_o,
    output logic [execute_pkg::XLEN-1:0]        fwd_value_o,
    output logic                                wb_we_o,
    output logic [execute_pkg::REG_ADDR_W-1:0]  wb_rd_addr_o,
    output logic [execute_pkg::XLEN-1:0]        wb_data_o
);

    import execute_pkg::*;

    // Operand stage to execute unit
    logic                  op_valid;
    logic [MICRO_OP_W-1:0] op_micro_op;
    logic [REG_ADDR_W-1:0] op_rd_addr;
    logic [XLEN-1:0]       op_pc_next;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic                  op_lt;
    logic                  op_ltu;
    logic                  op_eq;

    // Execute unit to write-back stage
    logic                  res_valid;
    logic [XLEN-1:0]       res_value;
    logic [MICRO_OP_W-1:0] res_micro_op;
    logic [REG_ADDR_W-1:0] res_rd_addr;
    logic [XLEN-1:0]       res_pc_next;

    operand_stage u_operand_stage (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .issue_valid_i (issue_valid_i),
        .accept_i      (ready_o),        // Issues only land while ready
        .micro_op_i    (micro_op_i),
        .rd_addr_i     (rd_addr_i),
        .pc_next_i     (pc_next_i),
        .operand_a_i   (operand_a_i),
        .operand_b_i   (operand_b_i),
        .op_valid_o    (op_valid),
        .micro_op_o    (op_micro_op),
        .rd_addr_o     (op_rd_addr),
        .pc_next_o     (op_pc_next),
        .operand_a_o   (op_a),
        .operand_b_o   (op_b),
        .lt_o          (op_lt),
        .ltu_o         (op_ltu),
        .eq_o          (op_eq)
    );

    execute_unit u_execute_unit (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .op_valid_i      (op_valid),
        .micro_op_i      (op_micro_op),
        .rd_addr_i       (op_rd_addr),
        .pc_next_i       (op_pc_next),
        .operand_a_i     (op_a),
        .operand_b_i     (op_b),
        .lt_i            (op_lt),
        .ltu_i           (op_ltu),
        .eq_i            (op_eq),
        .result_valid_o  (res_valid),
        .result_o        (res_value),
        .micro_op_o      (res_micro_op),
        .rd_addr_o       (res_rd_addr),
        .pc_next_o       (res_pc_next),
        .branch_target_o (branch_target_o),
        .branch_taken_o  (branch_taken_o),
        .fwd_value_o     (fwd_value_o),
        .ready_o         (ready_o)
    );

    writeback_stage u_writeback_stage (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .result_valid_i (res_valid),
        .result_i       (res_value),
        .micro_op_i     (res_micro_op),
        .rd_addr_i      (res_rd_addr),
        .pc_next_i      (res_pc_next),
        .wb_we_o        (wb_we_o),
        .wb_rd_addr_o   (wb_rd_addr_o),
        .wb_data_o      (wb_data_o)
    );

endmodule

`default_nettype wire

//--- tb/execute_vectors.svh
// Execute stage test table with stimulus and expected write-back and branch results per case
`ifndef EXECUTE_VECTORS_SVH
`define EXECUTE_VECTORS_SVH

task automatic build_table();
    logic [XLEN-1:0] pair_a [3];     // 0 equal, 1 signed less, 2 unsigned less
    logic [XLEN-1:0] pair_b [3];
    logic [XLEN-1:0] pair_sum [3];   // A+B, the expected target
    logic [2:0]      taken_tab [7];  // Bit p set when pair p takes the branch

    pair_a[0]   = 32'h00000100;
    pair_b[0]   = 32'h00000100;
    pair_sum[0] = 32'h00000200;
    pair_a[1]   = 32'hFFFFFFF0;      // -16 against 32, below only when signed
    pair_b[1]   = 32'h00000020;
    pair_sum[1] = 32'h00000010;
    pair_a[2]   = 32'h00000020;      // Below only when unsigned
    pair_b[2]   = 32'hFFFFFFF0;
    pair_sum[2] = 32'h00000010;

    taken_tab[BR_NONE] = 3'b000;
    taken_tab[BR_EQ]   = 3'b001;
    taken_tab[BR_NE]   = 3'b110;
    taken_tab[BR_LT]   = 3'b010;
    taken_tab[BR_GE]   = 3'b101;
    taken_tab[BR_LTU]  = 3'b100;
    taken_tab[BR_GEU]  = 3'b011;

    // name, micro-op, rd, pc_next, A, B, write data, write flag, taken, target
    push_row("add", alu_uop(ALU_ADD), 1, PC, 32'h00000010, 32'h00000025, 32'h00000035, 1, 0, 0);
    push_row("sub", alu_uop(ALU_SUB), 2, PC, 32'h00000005, 32'h00000007, 32'hFFFFFFFE, 1, 0, 0);
    push_row("sll", alu_uop(ALU_SLL), 3, PC, 32'h00000003, 32'h00000024, 32'h00000030, 1, 0, 0);
    push_row("srl", alu_uop(ALU_SRL), 4, PC, 32'h80000000, 32'h0000003F, 32'h00000001, 1, 0, 0);
    push_row("sra", alu_uop(ALU_SRA), 5, PC, 32'h80000000, 32'h00000004, 32'hF8000000, 1, 0, 0);
    push_row("and", alu_uop(ALU_AND), 6, PC, 32'hF0F0F0F0, 32'hFF00FF00, 32'hF000F000, 1, 0, 0);
    push_row("or", alu_uop(ALU_OR), 7, PC, 32'hF0F00000, 32'h00000F0F, 32'hF0F00F0F, 1, 0, 0);
    push_row("xor", alu_uop(ALU_XOR), 8, PC, 32'hFFFF0000, 32'hFF00FF00, 32'h00FFFF00, 1, 0, 0);
    push_row("slt_t", alu_uop(ALU_SLT), 9, PC, 32'hFFFFFFFF, 32'h00000001, 32'h1, 1, 0, 0);
    push_row("slt_f", alu_uop(ALU_SLT), 10, PC, 32'h00000005, 32'hFFFFFFFE, 32'h0, 1, 0, 0);
    push_row("sltu_f", alu_uop(ALU_SLTU), 11, PC, 32'hFFFFFFFF, 32'h00000001, 32'h0, 1, 0, 0);
    push_row("sltu_t", alu_uop(ALU_SLTU), 12, PC, 32'h00000001, 32'hFFFFFFFF, 32'h1, 1, 0, 0);
    push_row("rd_zero", alu_uop(ALU_ADD), 0, PC, 32'h00000011, 32'h00000022, 32'h33, 0, 0, 0);
    push_row("wb_off", make_uop(UNIT_ALU, ALU_ADD, BR_NONE, KIND_OTHER, WB_RESULT, 1'b0),
             13, PC, 32'h00000011, 32'h00000022, 32'h00000033, 0, 0, 0);
    push_row("jump", make_uop(UNIT_ALU, ALU_ADD, BR_NONE, KIND_JUMP, WB_PC_NEXT, 1'b1),
             14, 32'h00002004, 32'h00002000, 32'h00000040, 32'h00002004, 1, 1, 32'h00002040);
    push_row("mul", make_uop(UNIT_MUL, ALU_ADD, BR_NONE, KIND_OTHER, WB_RESULT, 1'b1),
             15, PC, 32'h00012345, 32'h00001000, 32'h12345000, 1, 0, 0);
    push_row("mul_neg", make_uop(UNIT_MUL, ALU_ADD, BR_NONE, KIND_OTHER, WB_RESULT, 1'b1),
             16, PC, 32'hFFFFFFFF, 32'h00000003, 32'hFFFFFFFD, 1, 0, 0);

    // Every condition against every operand pair, no write request
    for (int c = 0; c < 7; c++) begin
        for (int p = 0; p < 3; p++) begin
            push_row($sformatf("br%0d_pair%0d", c, p),
                     make_uop(UNIT_ALU, ALU_ADD, BR_COND_W'(c), KIND_BRANCH, WB_RESULT, 1'b0),
                     0, PC, pair_a[p], pair_b[p], 32'h0, 0, int'(taken_tab[c][p]), pair_sum[p]);
        end
    end
endtask

`endif

//--- tb/execute_tb.sv
// Testbench for the execute stage, table-driven over ALU, branch, jump and multiply cases
`default_nettype none
`timescale 1ns/1ps

module execute_tb;

    import execute_pkg::*;

    localparam int              PERIOD       = 40;
    localparam int              RESET_CYCLES = 10;
    localparam int              RANDOM_ROWS  = 4;
    localparam int              WB_WAIT      = MUL_CYCLES + 8;  // Cycles per row at most
    localparam logic [XLEN-1:0] PC           = 32'h0000_1004;   // Default next PC

    logic                  clk_i;
    logic                  rst_i;
    logic                  issue_valid_i;
    logic [MICRO_OP_W-1:0] micro_op_i;
    logic [REG_ADDR_W-1:0] rd_addr_i;
    logic [XLEN-1:0]       pc_next_i;
    logic [XLEN-1:0]       operand_a_i;
    logic [XLEN-1:0]       operand_b_i;
    logic                  ready_o;
    logic [XLEN-1:0]       branch_target_o;
    logic                  branch_taken_o;
    logic [XLEN-1:0]       fwd_value_o;
    logic                  wb_we_o;
    logic [REG_ADDR_W-1:0] wb_rd_addr_o;
    logic [XLEN-1:0]       wb_data_o;

    // Test table, one entry per row in every queue
    string                 name_q[$];
    logic [MICRO_OP_W-1:0] uop_q[$];
    logic [REG_ADDR_W-1:0] rd_q[$];
    logic [XLEN-1:0]       pc_q[$];
    logic [XLEN-1:0]       a_q[$];
    logic [XLEN-1:0]       b_q[$];
    logic [XLEN-1:0]       data_q[$];
    logic                  we_q[$];
    logic                  taken_q[$];
    logic [XLEN-1:0]       target_q[$];

    int   checks      = 0;
    int   errors      = 0;
    logic table_ready = 1'b0;

    execute_top DUT (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .issue_valid_i   (issue_valid_i),
        .micro_op_i      (micro_op_i),
        .rd_addr_i       (rd_addr_i),
        .pc_next_i       (pc_next_i),
        .operand_a_i     (operand_a_i),
        .operand_b_i     (operand_b_i),
        .ready_o         (ready_o),
        .branch_target_o (branch_target_o),
        .branch_taken_o  (branch_taken_o),
        .fwd_value_o     (fwd_value_o),
        .wb_we_o         (wb_we_o),
        .wb_rd_addr_o    (wb_rd_addr_o),
        .wb_data_o       (wb_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [MICRO_OP_W-1:0] make_uop(
        input logic [UNIT_W-1:0]    unit,
        input logic [ALU_OP_W-1:0]  op,
        input logic [BR_COND_W-1:0] cond,
        input logic [KIND_W-1:0]    kind,
        input logic                 sel,
        input logic                 en
    );
        logic [MICRO_OP_W-1:0] m;
        m = '0;
        m[UNIT_LSB +: UNIT_W]       = unit;
        m[ALU_OP_LSB +: ALU_OP_W]   = op;
        m[BR_COND_LSB +: BR_COND_W] = cond;
        m[KIND_LSB +: KIND_W]       = kind;
        m[WB_SEL_LSB]               = sel;
        m[WB_EN_LSB]                = en;
        return m;
    endfunction

    // Plain ALU op writing its result
    function automatic logic [MICRO_OP_W-1:0] alu_uop(input logic [ALU_OP_W-1:0] op);
        return make_uop(UNIT_ALU, op, BR_NONE, KIND_OTHER, WB_RESULT, 1'b1);
    endfunction

    task automatic push_row(
        input string                 name,
        input logic [MICRO_OP_W-1:0] uop,
        input int                    rd,
        input logic [XLEN-1:0]       pc_next,
        input logic [XLEN-1:0]       a,
        input logic [XLEN-1:0]       b,
        input logic [XLEN-1:0]       data,
        input int                    we,
        input int                    taken,
        input logic [XLEN-1:0]       target
    );
        name_q.push_back(name);
        uop_q.push_back(uop);
        rd_q.push_back(REG_ADDR_W'(rd));
        pc_q.push_back(pc_next);
        a_q.push_back(a);
        b_q.push_back(b);
        data_q.push_back(data);
        we_q.push_back(we != 0);
        taken_q.push_back(taken != 0);
        target_q.push_back(target);
    endtask

    `include "execute_vectors.svh"

    task automatic check_value(input string test, input string what,
                               input logic [XLEN-1:0] expected, input logic [XLEN-1:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    task automatic run_row(input int i);
        logic is_mul;
        logic is_ctrl;
        int   waited;
        is_mul  = (uop_q[i][UNIT_LSB +: UNIT_W] == UNIT_MUL);
        is_ctrl = (uop_q[i][KIND_LSB +: KIND_W] != KIND_OTHER);  // Branch or jump
        while (ready_o !== 1'b1) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        issue_valid_i <= 1'b1;
        micro_op_i    <= uop_q[i];
        rd_addr_i     <= rd_q[i];
        pc_next_i     <= pc_q[i];
        operand_a_i   <= a_q[i];
        operand_b_i   <= b_q[i];
        @(posedge clk_i);  // Issue sampled here
        issue_valid_i <= 1'b0;
        @(negedge clk_i);  // Cycle after issue
        check_value(name_q[i], "branch_taken_o", XLEN'(taken_q[i]), XLEN'(branch_taken_o));
        if (is_ctrl) begin
            check_value(name_q[i], "branch_target_o", target_q[i], branch_target_o);
        end
        if (is_mul) begin
            check_value(name_q[i], "ready_o busy", '0, XLEN'(ready_o));
            waited = 0;
            while (wb_we_o !== 1'b1 && waited < WB_WAIT) begin
                @(negedge clk_i);
                waited++;
            end
            checks++;
            assert (wb_we_o === 1'b1) else begin
                errors++;
                $display("%s: no write-back pulse within %0d cycles of the multiply",
                         name_q[i], WB_WAIT);
            end
            check_value(name_q[i], "ready_o done", 1, XLEN'(ready_o));  // Free again
        end else begin
            check_value(name_q[i], "fwd_value_o", is_ctrl ? target_q[i] : data_q[i],
                        fwd_value_o);
            @(negedge clk_i);  // Two edges after issue
            check_value(name_q[i], "wb_we_o", XLEN'(we_q[i]), XLEN'(wb_we_o));
        end
        if (we_q[i]) begin
            check_value(name_q[i], "wb_data_o", data_q[i], wb_data_o);
            check_value(name_q[i], "wb_rd_addr_o", XLEN'(rd_q[i]), XLEN'(wb_rd_addr_o));
        end
    endtask

    initial begin
        int              seed;
        logic [XLEN-1:0] ra;
        logic [XLEN-1:0] rb;
        seed          = 32'h8073;
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        micro_op_i    = '0;
        rd_addr_i     = '0;
        pc_next_i     = '0;
        operand_a_i   = '0;
        operand_b_i   = '0;
        build_table();
        for (int k = 0; k < RANDOM_ROWS; k++) begin
            ra = $random(seed);
            rb = $random(seed);
            push_row($sformatf("rand_add%0d", k), alu_uop(ALU_ADD), 17 + k, PC, ra, rb,
                     ra + rb, 1, 0, 0);
            push_row($sformatf("rand_mul%0d", k),
                     make_uop(UNIT_MUL, ALU_ADD, BR_NONE, KIND_OTHER, WB_RESULT, 1'b1),
                     21 + k, PC, ra, rb, ra * rb, 1, 0, 0);  // Low word of the product
        end
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_value("reset", "ready_o", 1, XLEN'(ready_o));
        check_value("reset", "wb_we_o", '0, XLEN'(wb_we_o));
        check_value("reset", "branch_taken_o", '0, XLEN'(branch_taken_o));
        for (int i = 0; i < name_q.size(); i++) begin
            run_row(i);
        end
        repeat (2) @(posedge clk_i);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        int limit;
        wait (table_ready);
        limit = (name_q.size() * WB_WAIT + RESET_CYCLES + 4) * PERIOD;
        #(limit);
        $display("Watchdog expired after %0d ns, the run is stuck", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- execute.f
+incdir+tb
rtl/execute_pkg.sv
rtl/operand_stage.sv
rtl/alu.sv
rtl/multiplier.sv
rtl/execute_unit.sv
rtl/writeback_stage.sv
rtl/execute_top.sv
tb/execute_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and scan the log
verilator --binary --timing --assert -Wno-fatal --top-module execute_tb \
    -f execute.f -Mdir obj_dir -o execute_sim > build.log 2>&1 ||
    { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/execute_sim > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
